// File: sim.f
+incdir+.
dial_input_pkg.sv
dial_quad_pkg.sv
dial_cfg_regs.sv
dial_step_gen.sv
dial_quad_encoder.sv
dial_position_counter.sv
dial_top.sv
tb_dial.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_dial -f sim.f -o tb_dial
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_dial > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST PASSED$" sim.log; then
    exit 0
fi
echo "Pass line not found in sim.log"
exit 1

// File: tb_dial.sv
// Dial emulation testbench
`timescale 1ns/1ps
`include "dial_params.svh"

module tb_dial
    import dial_input_pkg::*;
    import dial_quad_pkg::*;
();

    typedef logic signed [`DIAL_POS_W-1:0] pos_t;

    localparam int MODE_RAW  = 0;
    localparam int MODE_SPIN = 1;
    localparam int MODE_JOY  = 2;

    logic       clk;
    logic       rst_n;
    logic       lhbl;
    player_in_t p1;
    player_in_t p2;
    logic       cfg_wr;
    dial_cfg_t  cfg_wdata;
    logic       pos_clr;
    quad_t      dial_x;
    quad_t      dial_y;
    pos_t       pos_x;
    pos_t       pos_y;

    // Model state.
    // The exp values follow the counters, while net keeps every step since reset for the phase.
    int        exp_x;
    int        exp_y;
    int        net_x;
    int        net_y;
    int        line_cnt_m;
    dial_cfg_t cfg_m;
    int        err_count;
    int        timeout_count;
    event      scenario_done;

    dial_top dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .lhbl      (lhbl),
        .p1        (p1),
        .p2        (p2),
        .cfg_wr    (cfg_wr),
        .cfg_wdata (cfg_wdata),
        .pos_clr   (pos_clr),
        .dial_x    (dial_x),
        .dial_y    (dial_y),
        .pos_x     (pos_x),
        .pos_y     (pos_y)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Joystick pacing limit for each sensitivity.
    function automatic int joy_limit(input sensty_t s);
        case (s)
            2'd0:    return 8;
            2'd1:    return 15;
            2'd2:    return 1;
            default: return 4;
        endcase
    endfunction

    // Signed position change for one event or one joystick run.
    // A negative spinner burst in emulated mode is one step longer than a positive one.
    function automatic int expected_steps(input int mode, input sensty_t s, input bit dir,
                                          input bit rev, input int joy_lines);
        int n;
        case (mode)
            MODE_RAW:  n = 1;
            MODE_SPIN: n = dir ? 8 * int'(s ^ 2'd2) + 2 : 8 * int'(s ^ 2'd2) + 3;
            default:   n = joy_lines;
        endcase
        return (dir ^ rev) ? n : -n;
    endfunction

    // Phase after a net step count, on the forward Gray ring 00, 01, 11, 10.
    function automatic quad_t gray_of(input int net);
        logic [1:0] idx;
        quad_t      q;
        idx = net[1:0];
        q.a = idx[1];
        q.b = idx[1] ^ idx[0];
        return q;
    endfunction

    task automatic check_pos(input string name, input pos_t got, input pos_t exp);
        if (got !== exp) begin
            err_count++;
            $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_quad(input string name, input quad_t got, input quad_t exp);
        if (got !== exp) begin
            err_count++;
            $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    // The comparing process wakes once per finished scenario, at a falling edge.
    initial begin
        forever begin
            @(scenario_done);
            check_pos("pos_x", pos_x, pos_t'(exp_x));
            check_pos("pos_y", pos_y, pos_t'(exp_y));
            check_quad("dial_x", dial_x, gray_of(net_x));
            check_quad("dial_y", dial_y, gray_of(net_y));
        end
    end

    task automatic compare();
        -> scenario_done;
        @(posedge clk);
    endtask

    task automatic apply(input int dx, input int dy);
        exp_x += dx;
        exp_y += dy;
        net_x += dx;
        net_y += dy;
    endtask

    task automatic write_cfg(input bit raw, input sensty_t s, input bit rev);
        dial_cfg_t c;
        c.sensty  = s;
        c.raw     = raw;
        c.reverse = rev;
        cfg_m     = c;
        @(posedge clk);
        cfg_wr    <= 1'b1;
        cfg_wdata <= c;
        @(posedge clk);
        cfg_wr    <= 1'b0;
        @(posedge clk);
    endtask

    // Toggles the event line of each selected player with its direction.
    task automatic spin_events(input bit [1:0] which, input bit d1, input bit d2);
        @(posedge clk);
        if (which[0]) begin
            p1.spinner_dir <= d1;
            p1.spinner_evt <= ~p1.spinner_evt;
        end
        if (which[1]) begin
            p2.spinner_dir <= d2;
            p2.spinner_evt <= ~p2.spinner_evt;
        end
    endtask

    // One video line, high for two cycles and low for two.
    // The model keeps its own line counter and counts the joystick lines.
    task automatic run_line(inout int joy_lines);
        if (line_cnt_m < joy_limit(cfg_m.sensty)) begin
            joy_lines++;
        end
        line_cnt_m = (line_cnt_m + 1) % 16;
        @(posedge clk);
        lhbl <= 1'b1;
        repeat (2) @(posedge clk);
        lhbl <= 1'b0;
        @(posedge clk);
    endtask

    // Both positions must hold still for eight cycles; a burst steps every second cycle.
    task automatic wait_settle();
        pos_t lx;
        pos_t ly;
        int   quiet;
        int   n;
        quiet = 0;
        n     = 0;
        @(negedge clk);
        lx = pos_x;
        ly = pos_y;
        while (quiet < 8 && n < 600) begin
            @(negedge clk);
            n++;
            if (pos_x == lx && pos_y == ly) begin
                quiet++;
            end else begin
                quiet = 0;
            end
            lx = pos_x;
            ly = pos_y;
        end
        if (quiet < 8) begin
            timeout_count++;
            $display("Timeout: the positions kept moving for 600 cycles");
        end
    endtask

    initial begin
        logic [31:0] r;
        int          jl;
        logic [9:0]  joy_left;
        logic [9:0]  joy_right;
        void'($urandom(65));
        joy_left      = ~(10'b1 << `DIAL_LEFT_BIT);
        joy_right     = ~(10'b1 << (`DIAL_LEFT_BIT + 1));
        rst_n         = 1'b0;
        lhbl          = 1'b0;
        p1            = '{joystick: 10'h3ff, spinner_dir: 1'b0, spinner_evt: 1'b0};
        p2            = '{joystick: 10'h3ff, spinner_dir: 1'b0, spinner_evt: 1'b0};
        cfg_wr        = 1'b0;
        cfg_wdata     = '0;
        pos_clr       = 1'b0;
        exp_x         = 0;
        exp_y         = 0;
        net_x         = 0;
        net_y         = 0;
        line_cnt_m    = 0;
        cfg_m         = '0;
        err_count     = 0;
        timeout_count = 0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        wait_settle();
        compare();

        // Raw steps on player 1 only.
        write_cfg(1'b1, 2'd0, 1'b0);
        for (int i = 0; i < 12; i++) begin
            r = $urandom;
            spin_events(2'b01, r[0], 1'b0);
            wait_settle();
            apply(expected_steps(MODE_RAW, cfg_m.sensty, r[0], cfg_m.reverse, 0), 0);
            compare();
        end

        // Reverse flips raw steps on both players.
        write_cfg(1'b1, 2'd0, 1'b1);
        for (int i = 0; i < 8; i++) begin
            r = $urandom;
            spin_events(2'b11, r[0], r[1]);
            wait_settle();
            apply(expected_steps(MODE_RAW, cfg_m.sensty, r[0], cfg_m.reverse, 0),
                  expected_steps(MODE_RAW, cfg_m.sensty, r[1], cfg_m.reverse, 0));
            compare();
        end

        // Momentum bursts, each player in the opposite direction, then swapped.
        for (int s = 0; s < 4; s++) begin
            write_cfg(1'b0, sensty_t'(s), 1'b0);
            for (int k = 0; k < 2; k++) begin
                spin_events(2'b11, k == 0, k != 0);
                wait_settle();
                apply(expected_steps(MODE_SPIN, cfg_m.sensty, k == 0, 1'b0, 0),
                      expected_steps(MODE_SPIN, cfg_m.sensty, k != 0, 1'b0, 0));
                compare();
            end
        end

        // Joystick left, then right, paced by 32 lines each.
        write_cfg(1'b0, 2'd3, 1'b0);
        jl = 0;
        @(posedge clk);
        p1.joystick <= joy_left;
        repeat (32) run_line(jl);
        p1.joystick <= 10'h3ff;
        wait_settle();
        apply(expected_steps(MODE_JOY, cfg_m.sensty, 1'b1, 1'b0, jl), 0);
        compare();
        write_cfg(1'b0, 2'd1, 1'b0);
        jl = 0;
        @(posedge clk);
        p1.joystick <= joy_right;
        repeat (32) run_line(jl);
        p1.joystick <= 10'h3ff;
        wait_settle();
        apply(expected_steps(MODE_JOY, cfg_m.sensty, 1'b0, 1'b0, jl), 0);
        compare();

        // Clear, then count raw steps from zero; the phases are not cleared.
        @(posedge clk);
        pos_clr <= 1'b1;
        @(posedge clk);
        pos_clr <= 1'b0;
        wait_settle();
        exp_x = 0;
        exp_y = 0;
        compare();
        write_cfg(1'b1, 2'd0, 1'b0);
        for (int i = 0; i < 4; i++) begin
            r = $urandom;
            spin_events(2'b11, r[0], r[1]);
            wait_settle();
            apply(expected_steps(MODE_RAW, cfg_m.sensty, r[0], 1'b0, 0),
                  expected_steps(MODE_RAW, cfg_m.sensty, r[1], 1'b0, 0));
            compare();
        end

        $display("Done: %0d value errors, %0d timeouts", err_count, timeout_count);
        if (err_count == 0 && timeout_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: dial_top.sv
// Dial emulation top level
`timescale 1ns/1ps
`include "dial_params.svh"

module dial_top
    import dial_input_pkg::*;
    import dial_quad_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          lhbl,
    input  player_in_t                    p1,
    input  player_in_t                    p2,
    input  logic                          cfg_wr,
    input  dial_cfg_t                     cfg_wdata,
    input  logic                          pos_clr,
    output quad_t                         dial_x,
    output quad_t                         dial_y,
    output logic signed [`DIAL_POS_W-1:0] pos_x,
    output logic signed [`DIAL_POS_W-1:0] pos_y
);

    dial_cfg_t cfg;
    logic      clr;
    step_req_t step_x;
    step_req_t step_y;

    // Configuration and the shared clear pulse.
    dial_cfg_regs u_cfg (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_wr    (cfg_wr),
        .cfg_wdata (cfg_wdata),
        .pos_clr   (pos_clr),
        .cfg       (cfg),
        .clr       (clr)
    );

    // Player 1 drives the x axis and player 2 the y axis.
    dial_step_gen u_step (
        .clk    (clk),
        .rst_n  (rst_n),
        .lhbl   (lhbl),
        .p1     (p1),
        .p2     (p2),
        .cfg    (cfg),
        .step_x (step_x),
        .step_y (step_y)
    );

    dial_quad_encoder u_enc_x (
        .clk   (clk),
        .rst_n (rst_n),
        .step  (step_x),
        .quad  (dial_x)
    );

    dial_quad_encoder u_enc_y (
        .clk   (clk),
        .rst_n (rst_n),
        .step  (step_y),
        .quad  (dial_y)
    );

    // The counters decode the same phases the host chip would read.
    dial_position_counter u_pos_x (
        .clk   (clk),
        .rst_n (rst_n),
        .quad  (dial_x),
        .clr   (clr),
        .pos   (pos_x)
    );

    dial_position_counter u_pos_y (
        .clk   (clk),
        .rst_n (rst_n),
        .quad  (dial_y),
        .clr   (clr),
        .pos   (pos_y)
    );

endmodule

// File: dial_position_counter.sv
// Dial position counter
`timescale 1ns/1ps
`include "dial_params.svh"

module dial_position_counter
    import dial_quad_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst_n,
    input  quad_t                         quad,
    input  logic                          clr,
    output logic signed [`DIAL_POS_W-1:0] pos
);

    localparam logic signed [`DIAL_POS_W-1:0] POS_ONE = `DIAL_POS_W'(1);

    // Phase seen on the previous cycle.
    quad_t last_q;
    logic  fwd;
    logic  bwd;

    // Only a single-step move on the Gray ring counts.
    // A jump across the ring matches neither and is dropped.
    assign fwd = quad == quad_fwd(last_q);
    assign bwd = quad == quad_bwd(last_q);

    // Count follows the phase one edge after it changes.
    // Clear wins over a step on the same cycle.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            last_q <= '0;
            pos    <= '0;
        end else begin
            last_q <= quad;
            if (clr) begin
                pos <= '0;
            end else if (fwd) begin
                pos <= pos + POS_ONE;
            end else if (bwd) begin
                pos <= pos - POS_ONE;
            end
        end
    end

endmodule

// File: dial_quad_encoder.sv
// Dial quadrature encoder
`timescale 1ns/1ps

module dial_quad_encoder
    import dial_quad_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  step_req_t step,
    output quad_t     quad
);

    // A request is valid only with a pulse and exactly one direction.
    // A pulse with both or neither direction set is an idle joystick.
    logic step_ok;

    assign step_ok = step.pulse && (step.inc ^ step.dec);

    // The phase is the output itself, so the host sees it on the next edge.
    // Forward follows the Gray ring 00, 01, 11, 10 and backward walks it in reverse.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            quad <= '0;
        end else if (step_ok) begin
            quad <= step.inc ? quad_fwd(quad) : quad_bwd(quad);
        end
    end

    // The counter on the host side loses a step if both phases move together.
    a_gray_only : assert property (@(posedge clk) disable iff (!rst_n)
        $countones(quad ^ $past(quad)) <= 1);

endmodule

// File: dial_step_gen.sv
// Dial step generator
`timescale 1ns/1ps
`include "dial_params.svh"

module dial_step_gen
    import dial_input_pkg::*;
    import dial_quad_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       lhbl,
    input  player_in_t p1,
    input  player_in_t p2,
    input  dial_cfg_t  cfg,
    output step_req_t  step_x,
    output step_req_t  step_y
);

    localparam int LEFT_BIT  = `DIAL_LEFT_BIT;
    localparam int RIGHT_BIT = `DIAL_LEFT_BIT + 1;
    localparam int MW        = `DIAL_MOM_W;
    localparam logic [MW-1:0] MOM_ONE = MW'(1);

    logic            lhbl_l;
    logic            line_start;
    logic [3:0]      line_cnt;
    logic [3:0]      joy_limit;
    logic            joy_line;
    logic            cen;
    logic [MW-1:0]   mom_base;
    player_in_t      pin [2];
    logic [1:0]      last_evt;
    logic [1:0]      evt;
    logic [MW-1:0]   mom [2];
    step_req_t       req [2];

    // Reverse swaps the two directions after the source has picked them.
    function automatic step_req_t make_req(input logic pulse, input logic inc,
                                           input logic dec, input logic rev);
        step_req_t r;
        r.pulse = pulse;
        r.inc   = rev ? dec : inc;
        r.dec   = rev ? inc : dec;
        return r;
    endfunction

    // Index the players so one loop serves both.
    assign pin[0] = p1;
    assign pin[1] = p2;

    // A line start is the first cycle in which lhbl is seen high.
    assign line_start = lhbl & ~lhbl_l;

    // Joystick lines happen while the line counter is below the limit.
    // Sensitivity 1 is the fastest and 2 the slowest.
    always_comb begin
        unique case (cfg.sensty)
            2'd0:    joy_limit = 4'd8;
            2'd1:    joy_limit = 4'd15;
            2'd2:    joy_limit = 4'd1;
            default: joy_limit = 4'd4;
        endcase
    end

    assign joy_line = line_start && (line_cnt < joy_limit);

    // Burst length v is 8 times (sensty xor 2) plus 2.
    assign mom_base = {{(MW-5){1'b0}}, cfg.sensty ^ 2'b10, 3'd2};

    // Each change on a spinner toggle line is one event.
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            evt[i] = pin[i].spinner_evt != last_evt[i];
        end
    end

    // Line timing and the half-rate enable that paces momentum steps.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lhbl_l   <= lhbl;
            line_cnt <= '0;
            cen      <= 1'b0;
        end else begin
            lhbl_l <= lhbl;
            cen    <= ~cen;
            if (line_start) begin
                line_cnt <= line_cnt + 4'd1;
            end
        end
    end

    // Per-player step requests, all registered one cycle after their cause.
    // The toggle level follows the input even in reset, so no event is seen at release.
    always_ff @(posedge clk) begin
        for (int i = 0; i < 2; i++) begin
            last_evt[i] <= pin[i].spinner_evt;
            if (!rst_n) begin
                mom[i] <= '0;
                req[i] <= '0;
            end else if (cfg.raw) begin
                // Raw mode: one step per detent, in the spinner direction.
                mom[i] <= '0;
                req[i] <= make_req(evt[i], pin[i].spinner_dir, ~pin[i].spinner_dir,
                                   cfg.reverse);
            end else begin
                if (joy_line) begin
                    // Holding left steps forward, holding right steps backward.
                    req[i] <= make_req(1'b1, ~pin[i].joystick[LEFT_BIT],
                                       ~pin[i].joystick[RIGHT_BIT], cfg.reverse);
                end else if (cen && mom[i] != '0) begin
                    // The sign bit of the counter gives the burst direction.
                    req[i] <= make_req(1'b1, ~mom[i][MW-1], mom[i][MW-1], cfg.reverse);
                    mom[i] <= mom[i][MW-1] ? mom[i] + MOM_ONE : mom[i] - MOM_ONE;
                end else begin
                    req[i] <= '0;
                end
                // A new event restarts the burst, overriding any decay above.
                // Negative bursts start at 255-v and climb to zero, giving v+1 steps.
                if (evt[i]) begin
                    mom[i] <= pin[i].spinner_dir ? mom_base : ~mom_base;
                end
            end
        end
    end

    assign step_x = req[0];
    assign step_y = req[1];

    // In emulated mode a pulse needs a joystick line or live momentum one cycle earlier.
    a_no_idle_pulse : assert property (@(posedge clk) disable iff (!rst_n)
        (step_x.pulse || step_y.pulse) && !$past(cfg.raw)
        |-> $past(joy_line) || $past(mom[0] != '0) || $past(mom[1] != '0));

endmodule

// File: dial_cfg_regs.sv
// Dial configuration registers
`timescale 1ns/1ps

module dial_cfg_regs
    import dial_input_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      cfg_wr,
    input  dial_cfg_t cfg_wdata,
    input  logic      pos_clr,
    output dial_cfg_t cfg,
    output logic      clr
);

    // Last level of the external clear, used to find its rising edge.
    logic pos_clr_l;

    // The configuration word is latched on the write strobe.
    // The new value steers the step generator from the next cycle on.
    // The clear output is a single registered pulse per rising edge of pos_clr,
    // so a clear held for several cycles still zeroes the counters only once.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cfg       <= '0;
            pos_clr_l <= 1'b0;
            clr       <= 1'b0;
        end else begin
            if (cfg_wr) begin
                cfg <= cfg_wdata;
            end
            pos_clr_l <= pos_clr;
            clr       <= pos_clr & ~pos_clr_l;
        end
    end

    // Both position counters see this pulse; it must stay one cycle wide.
    a_clr_single : assert property (@(posedge clk) disable iff (!rst_n)
        clr |=> !clr);

endmodule

// File: dial_quad_pkg.sv
// Quadrature side types
package dial_quad_pkg;

    // A step request moves the encoder only when exactly one of inc or dec is set.
    typedef struct packed {
        logic pulse;
        logic inc;
        logic dec;
    } step_req_t;

    // Two-phase output as the dial controller chip sees it.
    typedef struct packed {
        logic a;
        logic b;
    } quad_t;

    // Forward Gray order is 00, 01, 11, 10.
    function automatic quad_t quad_fwd(input quad_t q);
        quad_t n;
        n.a = q.b;
        n.b = ~q.a;
        return n;
    endfunction

    // Backward order walks the same ring the other way.
    function automatic quad_t quad_bwd(input quad_t q);
        quad_t n;
        n.a = ~q.b;
        n.b = q.a;
        return n;
    endfunction

endpackage

// File: dial_input_pkg.sv
// Player input types
package dial_input_pkg;

    // Sensitivity selects both the joystick pacing and the spinner burst length.
    typedef logic [1:0] sensty_t;

    // One player's controls as they arrive from the input side.
    // The joystick buttons are active low.
    // The spinner event line toggles once per detent; its level carries no meaning.
    typedef struct packed {
        logic [9:0] joystick;
        logic       spinner_dir;
        logic       spinner_evt;
    } player_in_t;

    // Configuration word written by the host side.
    // Raw mode passes spinner detents straight through as single steps.
    // Reverse swaps the direction of every step.
    typedef struct packed {
        sensty_t sensty;
        logic    raw;
        logic    reverse;
    } dial_cfg_t;

endpackage

// File: dial_params.svh
// Dial emulation parameters
`ifndef DIAL_PARAMS_SVH
`define DIAL_PARAMS_SVH

// Index of the active-low left bit in the joystick word.
// The right bit sits at the next index up.
`define DIAL_LEFT_BIT 0

// Width of the signed position count kept for each axis.
// Sixteen bits is far more than a burst can move between host reads.
`define DIAL_POS_W 16

// Width of the momentum counter in the step generator.
// The top bit is the sign, so the largest burst must fit below half the range.
`define DIAL_MOM_W 8

`endif
